//--- vlog.f
+incdir+verif
verilog/lsu_pkg.sv
verilog/l1d_pkg.sv
verilog/lsu_queue.sv
verilog/lsu_issue_select.sv
verilog/l1d_port.sv
verilog/load_store_unit.sv
verif/tb_lsu.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the LSU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_lsu -f vlog.f

# Run status is decided by the pass message in the output
out=$(./obj_dir/Vtb_lsu || true)
echo "$out"
echo "$out" | grep -q "TEST OK"

//--- verif/tb_lsu_model.svh
`ifndef TB_LSU_MODEL_SVH
`define TB_LSU_MODEL_SVH

// ----------------------------------------------------------------------
// Random source and reference memory model
// ----------------------------------------------------------------------

// Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// Small address set so that loads and stores collide often
function automatic logic [ADDR_W-1:0] addr_of(input int k);
  return 64'h0000_0000_8000_0040 + (64'(k) * 64'd8);
endfunction

function automatic int addr_index(input logic [ADDR_W-1:0] addr);
  for (int k = 0; k < NUM_ADDR; k++) begin
    if (addr == addr_of(k)) begin
      return k;
    end
  end
  return 0;
endfunction

// Initial memory image mixing every address bit
function automatic logic [DATA_W-1:0] init_value(input logic [ADDR_W-1:0] addr);
  return {addr[31:0] ^ 32'h5a5a_0f0f, addr[63:32] ^ ~addr[31:0]};
endfunction

// Program run in order where the last older store to the address wins
function automatic logic [DATA_W-1:0] expected_load(input int idx);
  logic [DATA_W-1:0] v;
  v = init_value(prog_addr[idx]);
  for (int j = 0; j < idx; j++) begin
    if ((prog_op[j] == OP_STORE) && (prog_addr[j] == prog_addr[idx])) begin
      v = prog_value[j];
    end
  end
  return v;
endfunction

// ----------------------------------------------------------------------
// Compare tasks
// ----------------------------------------------------------------------
task automatic check_completion(input completion_t got, input completion_t exp);
  if (got !== exp) begin
    $display("error at %0t: completion tag 0x%0h value 0x%0h, expected tag 0x%0h value 0x%0h",
             $time, got.tag, got.value, exp.tag, exp.value);
    stop_failed();
  end
endtask

task automatic check_req(input l1d_req_t got, input l1d_req_t exp);
  if (got !== exp) begin
    $display("error at %0t: L1D request tag 0x%0h addr 0x%0h value 0x%0h we %0b",
             $time, got.tag, got.addr, got.value, got.we);
    $display("  expected tag 0x%0h addr 0x%0h value 0x%0h we %0b",
             exp.tag, exp.addr, exp.value, exp.we);
    stop_failed();
  end
endtask

`endif

//--- verif/tb_lsu.sv
`timescale 1ns/100ps

module tb_lsu;

  import lsu_pkg::*;
  import l1d_pkg::*;

  localparam int DEPTH     = 8;
  localparam int RAND_OPS  = 40;
  localparam int TOTAL_OPS = 2 * RAND_OPS + DEPTH;
  localparam int NUM_ADDR  = 4;
  // 40 cycles per operation plus reset
  localparam int WATCHDOG_CYCLES = TOTAL_OPS * 40 + 8;

  logic        clk_in;
  logic        rst_N_in;
  logic        instr_valid;
  instr_t      instr;
  logic        instr_ready;
  logic        data_valid;
  data_beat_t  data;
  logic        data_ready;
  logic        l1d_valid;
  l1d_req_t    l1d_req;
  logic        l1d_ready;
  logic        l1d_resp_valid;
  l1d_resp_t   l1d_resp;
  logic        completion_valid;
  completion_t completion;

  // Program of the running test indexed by tag
  op_e               prog_op    [256];
  logic [ADDR_W-1:0] prog_addr  [256];
  logic [DATA_W-1:0] prog_value [256];
  bit                accepted   [256];
  bit                done_flag  [256];
  bit                saw_req    [256];
  int                n_ops;
  int                done_count;
  int                last_store;
  int                fwd_count;
  bit                slow_mode;
  logic [DATA_W-1:0] l1d_mem [NUM_ADDR];
  logic [31:0]       stim_lfsr;
  logic [31:0]       l1d_lfsr;
  // L1D responder state
  bit                pending;
  bit                stalled;
  int                wait_cnt;
  l1d_req_t          held_req;
  l1d_resp_t         resp_hold;

  task automatic stop_failed();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    stop_failed();
  endtask

  `include "tb_lsu_model.svh"

  // Take n bits with one LFSR step per bit
  task automatic draw_bits(inout logic [31:0] st, input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      st = lfsr_next(st);
      v  = (v << 1) | int'(st[0]);
    end
  endtask

  initial clk_in = 1'b0;
  always #10 clk_in = ~clk_in;

  load_store_unit #(
    .QUEUE_DEPTH(DEPTH)
  ) uut (
    .clk_in           (clk_in),
    .rst_N_in         (rst_N_in),
    .instr_valid      (instr_valid),
    .instr            (instr),
    .instr_ready      (instr_ready),
    .data_valid       (data_valid),
    .data             (data),
    .data_ready       (data_ready),
    .l1d_valid        (l1d_valid),
    .l1d_req          (l1d_req),
    .l1d_ready        (l1d_ready),
    .l1d_resp_valid   (l1d_resp_valid),
    .l1d_resp         (l1d_resp),
    .completion_valid (completion_valid),
    .completion       (completion)
  );

  // ----------------------------------------------------------------------
  // One test with a random program and data beats out of order
  // ----------------------------------------------------------------------
  task automatic run_test(input int n, input bit hold_data, input bit slow);
    int pend[$];
    int next_i;
    int v;
    int pick;
    bit full_checked;
    for (int i = 0; i < 256; i++) begin
      accepted[i]  = 1'b0;
      done_flag[i] = 1'b0;
      saw_req[i]   = 1'b0;
    end
    for (int i = 0; i < n; i++) begin
      draw_bits(stim_lfsr, 1, v);
      prog_op[i] = v[0] ? OP_STORE : OP_LOAD;
      draw_bits(stim_lfsr, 2, v);
      prog_addr[i] = addr_of(v);
      draw_bits(stim_lfsr, 32, v);
      prog_value[i][63:32] = 32'(v);
      draw_bits(stim_lfsr, 32, v);
      prog_value[i][31:0] = 32'(v);
      // Loads carry no data
      if (prog_op[i] == OP_LOAD) begin
        prog_value[i] = '0;
      end
    end
    for (int a = 0; a < NUM_ADDR; a++) begin
      l1d_mem[a] = init_value(addr_of(a));
    end
    n_ops        = n;
    slow_mode    = slow;
    done_count   = 0;
    last_store   = -1;
    next_i       = 0;
    full_checked = 1'b0;
    while ((next_i < n) || (pend.size() != 0)) begin
      @(negedge clk_in);
      instr_valid = 1'b0;
      data_valid  = 1'b0;
      // Queue filled and nothing resolved so no room is left
      if (hold_data && (next_i == n) && !full_checked) begin
        if (instr_ready) begin
          abort_run("instr_ready stayed high with a full queue");
        end else if (!data_ready) begin
          abort_run("data_ready low while entries wait for data");
        end
        full_checked = 1'b1;
      end
      if ((pend.size() != 0) && (!hold_data || (next_i == n))) begin
        draw_bits(stim_lfsr, 2, v);
        if (v != 0) begin
          draw_bits(stim_lfsr, 3, pick);
          pick       = pick % pend.size();
          data_valid = 1'b1;
          data.tag   = 8'(pend[pick]);
          data.addr  = prog_addr[pend[pick]];
          data.value = prog_value[pend[pick]];
          pend.delete(pick);
        end
      end
      if ((next_i < n) && instr_ready) begin
        draw_bits(stim_lfsr, 1, v);
        if (v != 0) begin
          instr_valid      = 1'b1;
          instr.tag        = 8'(next_i);
          instr.op         = prog_op[next_i];
          accepted[next_i] = 1'b1;
          pend.push_back(next_i);
          next_i++;
        end
      end
    end
    @(negedge clk_in);
    instr_valid = 1'b0;
    data_valid  = 1'b0;
    while (done_count < n) begin
      @(negedge clk_in);
    end
    // Room returns once the head has stepped over freed slots
    while (!instr_ready) begin
      @(negedge clk_in);
    end
    // Every tag retired so no entry waits for data
    if (data_ready) begin
      abort_run("data_ready high with no entry waiting for data");
    end
  endtask

  initial begin
    rst_N_in       = 1'b0;
    instr_valid    = 1'b0;
    instr          = '0;
    data_valid     = 1'b0;
    data           = '0;
    l1d_ready      = 1'b0;
    l1d_resp_valid = 1'b0;
    l1d_resp       = '0;
    stim_lfsr      = 32'h2c2f;
    l1d_lfsr       = 32'h2c2f;
    n_ops          = 0;
    done_count     = 0;
    fwd_count      = 0;
    slow_mode      = 1'b0;
    repeat (8) @(negedge clk_in);
    rst_N_in = 1'b1;
    @(negedge clk_in);
    if (completion_valid || l1d_valid || data_ready || !instr_ready) begin
      abort_run("outputs not at their reset values after reset");
    end
    run_test(RAND_OPS, 1'b0, 1'b0);
    run_test(DEPTH, 1'b1, 1'b0);
    run_test(RAND_OPS, 1'b0, 1'b1);
    if (fwd_count == 0) begin
      abort_run("no load was served by store forwarding");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * 20);
    $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    stop_failed();
  end

  // ----------------------------------------------------------------------
  // Completion checker against the sequential program
  // ----------------------------------------------------------------------
  always @(negedge clk_in) begin : compare_completions
    int t;
    completion_t exp;
    if (rst_N_in && completion_valid) begin
      t = int'(completion.tag);
      if ((t >= n_ops) || !accepted[t] || done_flag[t]) begin
        abort_run($sformatf("completion for tag %0d that is not in flight", t));
      end else begin
        exp.tag   = completion.tag;
        exp.value = (prog_op[t] == OP_STORE) ? '0 : expected_load(t);
        check_completion(completion, exp);
        done_flag[t] = 1'b1;
        done_count++;
        // Load done without any L1D request was forwarded
        if ((prog_op[t] == OP_LOAD) && !saw_req[t]) begin
          fwd_count++;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // L1D responder with random ready and 1 to 4 cycle latency
  // ----------------------------------------------------------------------
  always @(negedge clk_in) begin : l1d_model
    int v;
    int t;
    int a;
    l1d_req_t exp;
    if (!rst_N_in) begin
      pending        = 1'b0;
      stalled        = 1'b0;
      wait_cnt       = 0;
      l1d_ready      = 1'b0;
      l1d_resp_valid = 1'b0;
    end else begin
      l1d_resp_valid = 1'b0;
      if (wait_cnt != 0) begin
        wait_cnt--;
        if (wait_cnt == 0) begin
          l1d_resp_valid = 1'b1;
          l1d_resp       = resp_hold;
          pending        = 1'b0;
        end
      end
      l1d_ready = 1'b0;
      if (l1d_valid && pending) begin
        abort_run("second L1D request while one is outstanding");
      end else if (l1d_valid) begin
        if (stalled) begin
          check_req(l1d_req, held_req);
        end
        // Slow mode keeps ready low for long stretches
        draw_bits(l1d_lfsr, slow_mode ? 3 : 1, v);
        if (v == 0) begin
          l1d_ready = 1'b1;
          stalled   = 1'b0;
          t         = int'(l1d_req.tag);
          if ((t >= n_ops) || !accepted[t] || done_flag[t]) begin
            abort_run($sformatf("L1D request for tag %0d that is not in flight", t));
          end else begin
            exp = '{tag: l1d_req.tag, addr: prog_addr[t], value: prog_value[t],
                    we: (prog_op[t] == OP_STORE)};
            check_req(l1d_req, exp);
            a = addr_index(l1d_req.addr);
            if (l1d_req.we && (t <= last_store)) begin
              abort_run($sformatf("store tag %0d reached the L1D out of program order", t));
            end else if (l1d_req.we) begin
              last_store      = t;
              l1d_mem[a]      = l1d_req.value;
              resp_hold.value = '0;
            end else begin
              saw_req[t]      = 1'b1;
              resp_hold.value = l1d_mem[a];
            end
            resp_hold.tag = l1d_req.tag;
            pending       = 1'b1;
            draw_bits(l1d_lfsr, 2, v);
            wait_cnt = v + 1;
          end
        end else begin
          held_req = l1d_req;
          stalled  = 1'b1;
        end
      end else if (stalled) begin
        abort_run("L1D request withdrawn before it was accepted");
      end
    end
  end

endmodule

//--- verilog/load_store_unit.sv
`timescale 1ns/100ps

module load_store_unit #(
  parameter int QUEUE_DEPTH = 8
) (
  input  logic                 clk_in,
  input  logic                 rst_N_in,
  // Processor instruction and data
  input  logic                 instr_valid,
  input  lsu_pkg::instr_t      instr,
  output logic                 instr_ready,
  input  logic                 data_valid,
  input  lsu_pkg::data_beat_t  data,
  output logic                 data_ready,
  // L1D
  output logic                 l1d_valid,
  output l1d_pkg::l1d_req_t    l1d_req,
  input  logic                 l1d_ready,
  input  logic                 l1d_resp_valid,
  input  l1d_pkg::l1d_resp_t   l1d_resp,
  // Completions to the processor
  output logic                 completion_valid,
  output lsu_pkg::completion_t completion
);

  import lsu_pkg::*;
  import l1d_pkg::*;

  localparam int IDX_W = $clog2(QUEUE_DEPTH);

  // Queue to select
  lsu_entry_t       entries [QUEUE_DEPTH];
  logic [IDX_W-1:0] head;
  logic [IDX_W:0]   occupied;
  issue_act_t       act;
  // Queue to L1D port
  logic             mem_issue;
  l1d_req_t         mem_req;
  logic             mem_idle;
  logic             mem_done;
  l1d_resp_t        mem_resp;

  // ---------------------------------------------------------------------
  // Ring queue, allocation through retirement
  // ---------------------------------------------------------------------
  lsu_queue #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) u_queue (
    .clk_in           (clk_in),
    .rst_N_in         (rst_N_in),
    .instr_valid      (instr_valid),
    .instr            (instr),
    .instr_ready      (instr_ready),
    .data_valid       (data_valid),
    .data             (data),
    .data_ready       (data_ready),
    .completion_valid (completion_valid),
    .completion       (completion),
    .entries          (entries),
    .head             (head),
    .occupied         (occupied),
    .act              (act),
    .mem_issue        (mem_issue),
    .mem_req          (mem_req),
    .mem_done         (mem_done),
    .mem_resp         (mem_resp)
  );

  // Forward or memory pick, one per cycle
  lsu_issue_select #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) u_select (
    .entries  (entries),
    .head     (head),
    .occupied (occupied),
    .mem_idle (mem_idle),
    .act      (act)
  );

  // Single outstanding L1D request
  l1d_port u_port (
    .clk_in         (clk_in),
    .rst_N_in       (rst_N_in),
    .mem_issue      (mem_issue),
    .mem_req        (mem_req),
    .mem_idle       (mem_idle),
    .mem_done       (mem_done),
    .mem_resp       (mem_resp),
    .l1d_valid      (l1d_valid),
    .l1d_req        (l1d_req),
    .l1d_ready      (l1d_ready),
    .l1d_resp_valid (l1d_resp_valid),
    .l1d_resp       (l1d_resp)
  );

endmodule

//--- verilog/l1d_port.sv
`timescale 1ns/100ps

module l1d_port (
  input  logic               clk_in,
  input  logic               rst_N_in,
  // Queue side
  input  logic               mem_issue,
  input  l1d_pkg::l1d_req_t  mem_req,
  output logic               mem_idle,
  output logic               mem_done,
  output l1d_pkg::l1d_resp_t mem_resp,
  // L1D side
  output logic               l1d_valid,
  output l1d_pkg::l1d_req_t  l1d_req,
  input  logic               l1d_ready,
  input  logic               l1d_resp_valid,
  input  l1d_pkg::l1d_resp_t l1d_resp
);

  import l1d_pkg::*;

  l1d_state_e state;

  // ---------------------------------------------------------------------
  // Handshake outputs
  // ---------------------------------------------------------------------
  // Busy as soon as a request strobe is pending
  assign mem_idle  = (state == S_IDLE) && !mem_issue;
  // Request on the bus only while waiting for ready
  assign l1d_valid = (state == S_REQ);

  // ---------------------------------------------------------------------
  // FSM
  // ---------------------------------------------------------------------
  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      state    <= S_IDLE;
      mem_done <= 1'b0;
    end else begin
      mem_done <= 1'b0;
      case (state)
        S_IDLE: begin
          // Latch the request, held until accepted
          if (mem_issue) begin
            l1d_req <= mem_req;
            state   <= S_REQ;
          end
        end
        S_REQ: begin
          if (l1d_ready) begin
            state <= S_WAIT;
          end
        end
        S_WAIT: begin
          // Single response, tag taken from the latched request
          if (l1d_resp_valid) begin
            mem_done       <= 1'b1;
            mem_resp.tag   <= l1d_req.tag;
            mem_resp.value <= l1d_resp.value;
            state          <= S_IDLE;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // ---------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------
  a_req_stable: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    l1d_valid && !l1d_ready |=> l1d_valid && $stable(l1d_req))
    else $error("L1D request changed under back-pressure");

  a_resp_tag: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    l1d_resp_valid |-> (state == S_WAIT) && (l1d_resp.tag == l1d_req.tag))
    else $error("L1D response tag 0x%0h not outstanding", l1d_resp.tag);

  a_issue_idle: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    mem_issue |-> state == S_IDLE)
    else $error("mem_issue while a request is outstanding");

endmodule

//--- verilog/lsu_issue_select.sv
`timescale 1ns/100ps

module lsu_issue_select #(
  parameter int QUEUE_DEPTH = 8
) (
  input  lsu_pkg::lsu_entry_t            entries [QUEUE_DEPTH],
  input  logic [$clog2(QUEUE_DEPTH)-1:0] head,
  input  logic [$clog2(QUEUE_DEPTH):0]   occupied,
  input  logic                           mem_idle,
  output lsu_pkg::issue_act_t            act
);

  import lsu_pkg::*;

  localparam int IDX_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = IDX_W + 1;

  // ---------------------------------------------------------------------
  // Age ordered scan from head
  // ---------------------------------------------------------------------
  always_comb begin
    logic [IDX_W-1:0]  idx;
    logic [IDX_W-1:0]  jdx;
    logic              found;
    logic              older_done;
    logic              stores_ok;
    logic              match_hit;
    logic              match_done;
    logic [DATA_W-1:0] match_value;

    act         = '{kind: ACT_NONE, slot: '0, value: '0};
    found       = 1'b0;
    older_done  = 1'b1;
    stores_ok   = 1'b1;
    match_hit   = 1'b0;
    match_done  = 1'b0;
    match_value = '0;
    jdx         = head;

    for (int k = 0; k < QUEUE_DEPTH; k++) begin
      idx = head + IDX_W'(k);
      if (!found && (CNT_W'(k) < occupied) && entries[idx].live) begin
        // Candidate needs data and must not be in flight or done
        if (entries[idx].resolved && !entries[idx].issued && !entries[idx].complete) begin
          if (entries[idx].op == OP_STORE) begin
            // Stores go out strictly in order
            if (mem_idle && older_done) begin
              found    = 1'b1;
              act.kind = ACT_MEMORY;
              act.slot = 8'(idx);
            end
          end else begin
            stores_ok   = 1'b1;
            match_hit   = 1'b0;
            match_done  = 1'b0;
            match_value = '0;
            // Walk the older slots, last matching store wins
            for (int j = 0; j < QUEUE_DEPTH; j++) begin
              jdx = head + IDX_W'(j);
              if ((j < k) && entries[jdx].live && (entries[jdx].op == OP_STORE)) begin
                if (!entries[jdx].resolved) begin
                  stores_ok = 1'b0;
                end else if (entries[jdx].addr == entries[idx].addr) begin
                  match_hit   = 1'b1;
                  match_done  = entries[jdx].complete;
                  match_value = entries[jdx].value;
                end
              end
            end
            if (stores_ok) begin
              if (match_hit && !match_done) begin
                // Store data still held in its slot
                found     = 1'b1;
                act.kind  = ACT_FORWARD;
                act.slot  = 8'(idx);
                act.value = match_value;
              end else if (mem_idle) begin
                // No pending store to this address, L1D has the value
                found    = 1'b1;
                act.kind = ACT_MEMORY;
                act.slot = 8'(idx);
              end
            end
          end
        end
        older_done = older_done & entries[idx].complete;
      end
    end
  end

  // One request at a time towards the L1D port
  always_comb begin
    a_mem_idle: assert final ((act.kind != ACT_MEMORY) || mem_idle)
      else $error("memory action selected while L1D port busy");
  end

endmodule

//--- verilog/lsu_queue.sv
`timescale 1ns/100ps

module lsu_queue #(
  parameter int QUEUE_DEPTH = 8
) (
  input  logic                           clk_in,
  input  logic                           rst_N_in,
  // Processor side
  input  logic                           instr_valid,
  input  lsu_pkg::instr_t                instr,
  output logic                           instr_ready,
  input  logic                           data_valid,
  input  lsu_pkg::data_beat_t            data,
  output logic                           data_ready,
  // Completions
  output logic                           completion_valid,
  output lsu_pkg::completion_t           completion,
  // Towards issue select
  output lsu_pkg::lsu_entry_t            entries [QUEUE_DEPTH],
  output logic [$clog2(QUEUE_DEPTH)-1:0] head,
  output logic [$clog2(QUEUE_DEPTH):0]   occupied,
  input  lsu_pkg::issue_act_t            act,
  // Towards the L1D port
  output logic                           mem_issue,
  output l1d_pkg::l1d_req_t              mem_req,
  input  logic                           mem_done,
  input  l1d_pkg::l1d_resp_t             mem_resp
);

  import lsu_pkg::*;

  localparam int IDX_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = IDX_W + 1;

  logic [IDX_W-1:0]       tail;
  logic [IDX_W-1:0]       act_idx;
  logic                   accept;
  logic                   head_free;
  logic [QUEUE_DEPTH-1:0] data_hits;
  logic [QUEUE_DEPTH-1:0] done_hits;
  logic                   cmpl_hit;
  logic [IDX_W-1:0]       cmpl_idx;

  // ---------------------------------------------------------------------
  // Status and matching
  // ---------------------------------------------------------------------
  // Room while fewer than QUEUE_DEPTH slots between head and tail
  assign instr_ready = (occupied != CNT_W'(QUEUE_DEPTH));
  assign accept      = instr_valid && instr_ready;
  // Head slot already retired and ready to be stepped over
  assign head_free   = (occupied != '0) && !entries[head].live;
  assign act_idx     = act.slot[IDX_W-1:0];

  always_comb begin
    data_ready = 1'b0;
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      // Live slot still without address and data
      data_ready   = data_ready | (entries[i].live && !entries[i].resolved);
      data_hits[i] = data_valid && entries[i].live && !entries[i].resolved &&
                     (entries[i].tag == data.tag);
      // Only an issued, unfinished slot takes a response
      done_hits[i] = mem_done && entries[i].live && entries[i].issued &&
                     !entries[i].complete && (entries[i].tag == mem_resp.tag);
    end
  end

  // Oldest complete slot searched from head in age order
  always_comb begin
    logic [IDX_W-1:0] idx;
    cmpl_hit = 1'b0;
    cmpl_idx = head;
    for (int k = 0; k < QUEUE_DEPTH; k++) begin
      idx = head + IDX_W'(k);
      if (!cmpl_hit && (CNT_W'(k) < occupied) && entries[idx].live &&
          entries[idx].complete) begin
        cmpl_hit = 1'b1;
        cmpl_idx = idx;
      end
    end
  end

  // ---------------------------------------------------------------------
  // Queue state
  // ---------------------------------------------------------------------
  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
        entries[i].live     <= 1'b0;
        entries[i].resolved <= 1'b0;
        entries[i].issued   <= 1'b0;
        entries[i].complete <= 1'b0;
      end
      head             <= '0;
      tail             <= '0;
      occupied         <= '0;
      mem_issue        <= 1'b0;
      completion_valid <= 1'b0;
    end else begin
      mem_issue        <= 1'b0;
      completion_valid <= 1'b0;

      // Allocate at tail where the slot is never live
      if (accept) begin
        entries[tail].live     <= 1'b1;
        entries[tail].resolved <= 1'b0;
        entries[tail].issued   <= 1'b0;
        entries[tail].complete <= 1'b0;
        entries[tail].tag      <= instr.tag;
        entries[tail].op       <= instr.op;
        tail                   <= tail + 1'b1;
      end

      for (int i = 0; i < QUEUE_DEPTH; i++) begin
        // Address and data arrive by tag
        if (data_hits[i]) begin
          entries[i].resolved <= 1'b1;
          entries[i].addr     <= data.addr;
          entries[i].value    <= data.value;
        end
        // Response write back with zero for stores
        if (done_hits[i]) begin
          entries[i].complete <= 1'b1;
          entries[i].value    <= (entries[i].op == OP_LOAD) ? mem_resp.value : '0;
        end
      end

      // Action picked by the issue scan
      case (act.kind)
        ACT_FORWARD: begin
          entries[act_idx].complete <= 1'b1;
          entries[act_idx].value    <= act.value;
        end
        ACT_MEMORY: begin
          entries[act_idx].issued <= 1'b1;
          mem_issue               <= 1'b1;
          mem_req.tag             <= entries[act_idx].tag;
          mem_req.addr            <= entries[act_idx].addr;
          mem_req.value           <= entries[act_idx].value;
          mem_req.we              <= (entries[act_idx].op == OP_STORE);
        end
        default: ;
      endcase

      // One completion per cycle frees its slot
      if (cmpl_hit) begin
        completion_valid       <= 1'b1;
        completion.tag         <= entries[cmpl_idx].tag;
        completion.value       <= entries[cmpl_idx].value;
        entries[cmpl_idx].live <= 1'b0;
      end

      if (head_free) begin
        head <= head + 1'b1;
      end
      occupied <= occupied + CNT_W'(accept) - CNT_W'(head_free);
    end
  end

  // ---------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------
  // An accepted instruction only lands on a free slot
  a_full_holds: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    accept |-> !entries[tail].live)
    else $error("instruction accepted while no slot was free");

  a_data_match: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    data_valid |-> $onehot(data_hits))
    else $error("data beat tag 0x%0h matches no single waiting entry", data.tag);

  a_done_match: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    mem_done |-> $onehot(done_hits))
    else $error("mem_done tag 0x%0h matches no issued entry", mem_resp.tag);

endmodule

//--- verilog/l1d_pkg.sv
package l1d_pkg;

  // ---------------------------------------------------------------------
  // L1D request and response
  // ---------------------------------------------------------------------

  // Single request towards the L1D, we set for stores
  typedef struct packed {
    logic [lsu_pkg::TAG_W-1:0]  tag;
    logic [lsu_pkg::ADDR_W-1:0] addr;
    logic [lsu_pkg::DATA_W-1:0] value;
    logic                       we;
  } l1d_req_t;

  // Answer to the one outstanding request
  typedef struct packed {
    logic [lsu_pkg::TAG_W-1:0]  tag;
    logic [lsu_pkg::DATA_W-1:0] value;
  } l1d_resp_t;

  // L1D port FSM
  typedef enum logic [1:0] {
    // Free for a new request
    S_IDLE = 2'd0,
    // Request on the bus, waiting for ready
    S_REQ  = 2'd1,
    // Accepted, waiting for the response
    S_WAIT = 2'd2
  } l1d_state_e;

endpackage

//--- verilog/lsu_pkg.sv
package lsu_pkg;

  // ---------------------------------------------------------------------
  // Widths on the processor side
  // ---------------------------------------------------------------------
  localparam int ADDR_W = 64;
  localparam int DATA_W = 64;
  localparam int TAG_W  = 8;

  // Memory instruction kind
  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } op_e;

  // What the issue scan decided for this cycle
  typedef enum logic [1:0] {
    ACT_NONE    = 2'd0,
    ACT_FORWARD = 2'd1,
    ACT_MEMORY  = 2'd2
  } act_e;

  // Instruction announced by the processor, data comes later by tag
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    op_e              op;
  } instr_t;

  // Address and store data for an announced tag
  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] value;
  } data_beat_t;

  // One ring queue slot
  typedef struct packed {
    logic              live;
    // Address and data have arrived
    logic              resolved;
    // Request handed to the L1D port
    logic              issued;
    // Result present, waiting to retire
    logic              complete;
    logic [TAG_W-1:0]  tag;
    op_e               op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] value;
  } lsu_entry_t;

  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [DATA_W-1:0] value;
  } completion_t;

  // Slot index is 8 bits wide, enough for 256 slots
  typedef struct packed {
    act_e              kind;
    logic [7:0]        slot;
    logic [DATA_W-1:0] value;
  } issue_act_t;

endpackage
